//--- source/rob_pkg.sv
package rob_pkg;

    // lanes per dispatch group and per retire group
    localparam int PUSH_WIDTH = 3;

    // usable reorder buffer entries
    localparam int ELEMENTS = 15;

    // one storage slot always stays empty so full and empty differ
    localparam int SLOTS = ELEMENTS + 1;

    // an entry tag is simply the storage index of the entry
    localparam int TAG_WIDTH = $clog2(SLOTS);

    // wide enough to count from zero up to PUSH_WIDTH
    localparam int CT_WIDTH = $clog2(PUSH_WIDTH + 1);

    // instruction payload as carried through the system, done flag excluded
    localparam int PAYLOAD_WIDTH = 10;

    // class bit selects the execution unit
    localparam int PL_CLASS_BIT = 0;

    // latency field L in cycles
    localparam int PL_LAT_LSB = 1;
    localparam int PL_LAT_WIDTH = 3;

    // free identifier so instructions can be told apart
    localparam int PL_ID_LSB = PL_LAT_LSB + PL_LAT_WIDTH;
    localparam int PL_ID_WIDTH = 6;

    // execution units sharing the completion path
    localparam int NUM_UNITS = 2;
    localparam int UNIT_SEL_WIDTH = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

endpackage

//--- source/rob.sv
`timescale 1ns/1ps

module rob
    import rob_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] din,
    input  logic [CT_WIDTH-1:0]                     din_valid_ct,
    output logic [CT_WIDTH-1:0]                     din_ready_ct,
    output logic [PUSH_WIDTH-1:0][TAG_WIDTH-1:0]     entry_nums,
    output logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] dout,
    output logic [CT_WIDTH-1:0]                     dout_valid_ct,
    input  logic [CT_WIDTH-1:0]                     dout_ready_ct,
    input  logic [TAG_WIDTH-1:0]                    cmplt_tag,
    input  logic                                    cmplt_valid
);

    logic [PAYLOAD_WIDTH-1:0] mem [SLOTS];
    logic [SLOTS-1:0] done;
    logic [TAG_WIDTH-1:0] rd_ptr;
    logic [TAG_WIDTH-1:0] wr_ptr;
    logic [TAG_WIDTH:0] occupied;
    logic [TAG_WIDTH:0] available;
    logic [CT_WIDTH-1:0] num_push;
    logic [CT_WIDTH-1:0] num_pop;
    logic [PUSH_WIDTH-1:0][TAG_WIDTH-1:0] rd_idx;
    logic run_open;

    // circular index arithmetic, offset never exceeds one wrap
    function automatic logic [TAG_WIDTH-1:0] slot_add(input logic [TAG_WIDTH-1:0] base,
                                                      input int off);
        logic [TAG_WIDTH:0] sum;
        sum = {1'b0, base} + (TAG_WIDTH+1)'(off);
        if (sum >= (TAG_WIDTH+1)'(SLOTS)) begin
            sum = sum - (TAG_WIDTH+1)'(SLOTS);
        end
        return sum[TAG_WIDTH-1:0];
    endfunction

    assign occupied = (wr_ptr >= rd_ptr) ? {1'b0, wr_ptr} - {1'b0, rd_ptr}
                                         : {1'b0, wr_ptr} + (TAG_WIDTH+1)'(SLOTS) - {1'b0, rd_ptr};
    assign available = (TAG_WIDTH+1)'(ELEMENTS) - occupied;

    // ready depends on pointers only, never on the valid count
    assign din_ready_ct = (available >= (TAG_WIDTH+1)'(PUSH_WIDTH)) ? CT_WIDTH'(PUSH_WIDTH)
                                                                    : available[CT_WIDTH-1:0];
    assign num_push = (din_valid_ct < din_ready_ct) ? din_valid_ct : din_ready_ct;
    assign num_pop = (dout_valid_ct < dout_ready_ct) ? dout_valid_ct : dout_ready_ct;

    always_comb begin : lane_index
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            entry_nums[i] = slot_add(wr_ptr, i);
            rd_idx[i] = slot_add(rd_ptr, i);
        end
    end

    // count the unbroken run of done entries starting at the head
    always_comb begin : head_run
        dout_valid_ct = '0;
        run_open = 1'b1;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            dout[i] = mem[rd_idx[i]];
            if (run_open && ((TAG_WIDTH+1)'(i) < occupied) && done[rd_idx[i]]) begin
                dout_valid_ct = dout_valid_ct + CT_WIDTH'(1);
            end else begin
                run_open = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            done <= '0;
        end else begin
            // a freshly written entry starts out not done
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                if (CT_WIDTH'(i) < num_push) begin
                    done[entry_nums[i]] <= 1'b0;
                end
            end
            // completions only target occupied slots so they never meet a new write
            if (cmplt_valid) begin
                done[cmplt_tag] <= 1'b1;
            end
            wr_ptr <= slot_add(wr_ptr, int'(num_push));
            rd_ptr <= slot_add(rd_ptr, int'(num_pop));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            if (CT_WIDTH'(i) < num_push) begin
                mem[entry_nums[i]] <= din[i];
            end
        end
    end

endmodule

//--- source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import rob_pkg::*;
#(
    parameter bit UNIT_CLASS = 1'b0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] din,
    input  logic [CT_WIDTH-1:0]                     din_valid_ct,
    input  logic [CT_WIDTH-1:0]                     din_ready_ct,
    input  logic [PUSH_WIDTH-1:0][TAG_WIDTH-1:0]     entry_nums,
    output logic                                    req,
    output logic [TAG_WIDTH-1:0]                    tag,
    input  logic                                    ack
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_t;

    hs_state_t state;
    logic [SLOTS-1:0] busy;
    logic [PL_LAT_WIDTH-1:0] count [SLOTS];
    logic [SLOTS-1:0] finished;
    logic [CT_WIDTH-1:0] num_accept;
    logic [PUSH_WIDTH-1:0] take;
    logic [TAG_WIDTH-1:0] pick;
    logic pick_valid;

    assign num_accept = (din_valid_ct < din_ready_ct) ? din_valid_ct : din_ready_ct;
    assign req = (state == HS_REQ);

    // only accepted lanes of this unit's class get a timer
    always_comb begin
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            take[i] = (CT_WIDTH'(i) < num_accept) && (din[i][PL_CLASS_BIT] == UNIT_CLASS);
        end
    end

    // walk downwards so the lowest finished tag wins
    always_comb begin
        pick = '0;
        pick_valid = 1'b0;
        for (int t = SLOTS - 1; t >= 0; t--) begin
            finished[t] = busy[t] && (count[t] == '0);
            if (finished[t]) begin
                pick = TAG_WIDTH'(t);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            state <= HS_IDLE;
        end else begin
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                if (take[i]) begin
                    busy[entry_nums[i]] <= 1'b1;
                end
            end
            case (state)
                HS_IDLE: if (pick_valid) state <= HS_REQ;
                HS_REQ: begin
                    if (ack) begin
                        busy[tag] <= 1'b0;
                        state <= HS_RELEASE;
                    end
                end
                // wait for the arbiter to drop ack before choosing again
                HS_RELEASE: if (!ack) state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HS_IDLE && pick_valid) begin
            tag <= pick;
        end
        for (int t = 0; t < SLOTS; t++) begin
            if (busy[t] && count[t] != '0) begin
                count[t] <= count[t] - PL_LAT_WIDTH'(1);
            end
        end
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            if (take[i]) begin
                count[entry_nums[i]] <= din[i][PL_LAT_LSB +: PL_LAT_WIDTH];
            end
        end
    end

endmodule

//--- source/cmplt_arbiter.sv
`timescale 1ns/1ps

module cmplt_arbiter
    import rob_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [NUM_UNITS-1:0]                 unit_req,
    input  logic [NUM_UNITS-1:0][TAG_WIDTH-1:0]  unit_tag,
    output logic [NUM_UNITS-1:0]                 unit_ack,
    output logic [TAG_WIDTH-1:0]                 cmplt_tag,
    output logic                                 cmplt_valid
);

    // last unit granted, also the holder while its ack is high
    logic [UNIT_SEL_WIDTH-1:0] last;
    logic [UNIT_SEL_WIDTH-1:0] next_sel;
    logic next_found;
    logic grant;

    // search starts at the unit after the last one granted
    always_comb begin
        int idx;
        next_sel = last;
        next_found = 1'b0;
        for (int off = 1; off <= NUM_UNITS; off++) begin
            idx = (int'(last) + off) % NUM_UNITS;
            if (!next_found && unit_req[idx]) begin
                next_sel = UNIT_SEL_WIDTH'(idx);
                next_found = 1'b1;
            end
        end
    end

    assign grant = (unit_ack == '0) && next_found;

    always_ff @(posedge clk) begin
        if (rst) begin
            unit_ack <= '0;
            cmplt_valid <= 1'b0;
            last <= UNIT_SEL_WIDTH'(NUM_UNITS - 1);
        end else begin
            cmplt_valid <= grant;
            if (grant) begin
                unit_ack[next_sel] <= 1'b1;
                last <= next_sel;
            end else if (unit_ack != '0 && !unit_req[last]) begin
                unit_ack[last] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            cmplt_tag <= unit_tag[next_sel];
        end
    end

endmodule

//--- source/rob_core.sv
`timescale 1ns/1ps

module rob_core
    import rob_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] din,
    input  logic [CT_WIDTH-1:0]                     din_valid_ct,
    output logic [CT_WIDTH-1:0]                     din_ready_ct,
    output logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] dout,
    output logic [CT_WIDTH-1:0]                     dout_valid_ct,
    input  logic [CT_WIDTH-1:0]                     dout_ready_ct,
    output logic [PUSH_WIDTH-1:0][TAG_WIDTH-1:0]     entry_nums
);

    logic [NUM_UNITS-1:0] unit_req;
    logic [NUM_UNITS-1:0][TAG_WIDTH-1:0] unit_tag;
    logic [NUM_UNITS-1:0] unit_ack;
    logic [TAG_WIDTH-1:0] cmplt_tag;
    logic cmplt_valid;

    rob rob_i (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .din_valid_ct  (din_valid_ct),
        .din_ready_ct  (din_ready_ct),
        .entry_nums    (entry_nums),
        .dout          (dout),
        .dout_valid_ct (dout_valid_ct),
        .dout_ready_ct (dout_ready_ct),
        .cmplt_tag     (cmplt_tag),
        .cmplt_valid   (cmplt_valid)
    );

    // both units watch the same dispatch group and keep their own class
    exec_unit #(.UNIT_CLASS(1'b0)) exec_unit_0_i (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .entry_nums   (entry_nums),
        .req          (unit_req[0]),
        .tag          (unit_tag[0]),
        .ack          (unit_ack[0])
    );

    exec_unit #(.UNIT_CLASS(1'b1)) exec_unit_1_i (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .entry_nums   (entry_nums),
        .req          (unit_req[1]),
        .tag          (unit_tag[1]),
        .ack          (unit_ack[1])
    );

    cmplt_arbiter cmplt_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .unit_req    (unit_req),
        .unit_tag    (unit_tag),
        .unit_ack    (unit_ack),
        .cmplt_tag   (cmplt_tag),
        .cmplt_valid (cmplt_valid)
    );

endmodule

//--- tb/rob_tb_model.svh
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// one dispatched instruction as the model remembers it
typedef struct {
    logic [PAYLOAD_WIDTH-1:0] payload;
    int accept_cycle;
    int lat;
} rob_entry_t;

// entries in dispatch order, oldest at the front
rob_entry_t pending_q[$];
logic [TAG_WIDTH-1:0] model_wr_ptr;
int dispatched_total;
int retired_total;

function automatic int occupancy();
    return pending_q.size();
endfunction

function automatic logic [CT_WIDTH-1:0] expected_ready();
    int room;
    room = ELEMENTS - pending_q.size();
    return (room < PUSH_WIDTH) ? CT_WIDTH'(room) : CT_WIDTH'(PUSH_WIDTH);
endfunction

// tags are storage indices handed out in order around the ring
function automatic logic [TAG_WIDTH-1:0] expected_tag(input int lane);
    return TAG_WIDTH'((int'(model_wr_ptr) + lane) % SLOTS);
endfunction

task automatic clear_model();
    pending_q.delete();
    model_wr_ptr = '0;
    dispatched_total = 0;
    retired_total = 0;
endtask

task automatic record_accept(input logic [PAYLOAD_WIDTH-1:0] payload, input int cycle);
    rob_entry_t e;
    e.payload = payload;
    e.accept_cycle = cycle;
    e.lat = int'(payload[PL_LAT_LSB +: PL_LAT_WIDTH]);
    pending_q.push_back(e);
    model_wr_ptr = expected_tag(1);
    dispatched_total++;
endtask

task automatic retire_front();
    void'(pending_q.pop_front());
    retired_total++;
endtask

// countdown, request, grant and done flag each cost at least one edge
task automatic verify_retire_time(input int lane, input int now_cycle);
    int waited;
    waited = now_cycle - pending_q[lane].accept_cycle;
    if (waited < pending_q[lane].lat + 3) begin
        other_errors++;
        $display("at %0t: retire lane %0d was ready %0d cycles after dispatch, minimum %0d",
                 $time, lane, waited, pending_q[lane].lat + 3);
    end
endtask

`endif

//--- tb/rob_core_tb.sv
`timescale 1ns/1ps

module rob_core_tb
    import rob_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_CYCLES = 1800;
    localparam int STALL_CYCLES = 100;
    localparam int DRAIN_CYCLES = 100;
    localparam int TEST_CYCLES = RANDOM_CYCLES + STALL_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN_CYCLES = 200;
    localparam int SEED = 19280;

    logic clk;
    logic rst;
    logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] din;
    logic [CT_WIDTH-1:0] din_valid_ct;
    logic [CT_WIDTH-1:0] din_ready_ct;
    logic [PUSH_WIDTH-1:0][PAYLOAD_WIDTH-1:0] dout;
    logic [CT_WIDTH-1:0] dout_valid_ct;
    logic [CT_WIDTH-1:0] dout_ready_ct;
    logic [PUSH_WIDTH-1:0][TAG_WIDTH-1:0] entry_nums;

    int mismatch_errors;
    int other_errors;
    // rising edges since the last reset edge
    int cycle_no;

    `include "rob_tb_model.svh"

    rob_core dut_i (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .din_valid_ct  (din_valid_ct),
        .din_ready_ct  (din_ready_ct),
        .dout          (dout),
        .dout_valid_ct (dout_valid_ct),
        .dout_ready_ct (dout_ready_ct),
        .entry_nums    (entry_nums)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic compare_count(input string name, input logic [CT_WIDTH-1:0] got,
                                 input logic [CT_WIDTH-1:0] exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_payload(input string name, input logic [PAYLOAD_WIDTH-1:0] got,
                                   input logic [PAYLOAD_WIDTH-1:0] exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_tag(input string name, input logic [TAG_WIDTH-1:0] got,
                               input logic [TAG_WIDTH-1:0] exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic logic [PAYLOAD_WIDTH-1:0] random_payload();
        logic [PAYLOAD_WIDTH-1:0] p;
        p = '0;
        p[PL_CLASS_BIT] = 1'($urandom % 2);
        p[PL_LAT_LSB +: PL_LAT_WIDTH] = PL_LAT_WIDTH'($urandom % (1 << PL_LAT_WIDTH));
        p[PL_ID_LSB +: PL_ID_WIDTH] = PL_ID_WIDTH'($urandom % (1 << PL_ID_WIDTH));
        return p;
    endfunction

    // sampled mid cycle, then the model takes what the next edge will do
    task automatic check_outputs();
        logic [CT_WIDTH-1:0] ready_exp;
        int n_pop;
        int n_push;
        ready_exp = expected_ready();
        compare_count("din_ready_ct", din_ready_ct, ready_exp);
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            compare_tag($sformatf("entry_nums[%0d]", i), entry_nums[i], expected_tag(i));
        end
        if (int'(dout_valid_ct) > occupancy()) begin
            other_errors++;
            $display("at %0t: dout_valid_ct of %0d is more than the %0d entries held",
                     $time, dout_valid_ct, occupancy());
        end
        for (int i = 0; i < int'(dout_valid_ct) && i < occupancy(); i++) begin
            compare_payload($sformatf("dout[%0d]", i), dout[i], pending_q[i].payload);
            verify_retire_time(i, cycle_no);
        end
        n_pop = (dout_valid_ct < dout_ready_ct) ? int'(dout_valid_ct) : int'(dout_ready_ct);
        for (int i = 0; i < n_pop && occupancy() > 0; i++) begin
            retire_front();
        end
        n_push = (din_valid_ct < ready_exp) ? int'(din_valid_ct) : int'(ready_exp);
        for (int i = 0; i < n_push; i++) begin
            record_accept(din[i], cycle_no + 1);
        end
    endtask

    task automatic step(input logic [CT_WIDTH-1:0] valid_ct, input logic [CT_WIDTH-1:0] ready_ct);
        @(posedge clk);
        cycle_no++;
        #(DRIVE_DELAY);
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            din[i] = random_payload();
        end
        din_valid_ct = valid_ct;
        dout_ready_ct = ready_ct;
        #(CLK_PERIOD / 2 - DRIVE_DELAY);
        check_outputs();
    endtask

    initial begin
        void'($urandom(SEED));
        mismatch_errors = 0;
        other_errors = 0;
        cycle_no = 0;
        rst = 1'b1;
        din = '0;
        din_valid_ct = '0;
        dout_ready_ct = '0;
        clear_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        #(CLK_PERIOD / 2 - DRIVE_DELAY);
        compare_count("din_ready_ct", din_ready_ct, CT_WIDTH'(PUSH_WIDTH));
        compare_count("dout_valid_ct", dout_valid_ct, '0);

        repeat (RANDOM_CYCLES) begin
            step(CT_WIDTH'($urandom % (PUSH_WIDTH + 1)), CT_WIDTH'($urandom % (PUSH_WIDTH + 1)));
        end

        // a blocked consumer must fill the buffer and refuse dispatch
        repeat (STALL_CYCLES) step(CT_WIDTH'(PUSH_WIDTH), '0);
        compare_count("din_ready_ct", din_ready_ct, '0);

        repeat (DRAIN_CYCLES) step('0, CT_WIDTH'(PUSH_WIDTH));
        if (occupancy() != 0 || dispatched_total != retired_total) begin
            other_errors++;
            $display("at %0t: %0d instructions dispatched but %0d retired after draining",
                     $time, dispatched_total, retired_total);
        end

        $display("error summary: %0d mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rob_core.f
+incdir+tb
source/rob_pkg.sv
source/rob.sv
source/exec_unit.sv
source/cmplt_arbiter.sv
source/rob_core.sv
tb/rob_core_tb.sv

//--- Makefile
# any of these can be overridden, for example: make test LOG=run.log
VERILATOR ?= verilator
TOP ?= rob_core_tb
FILELIST ?= rob_core.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
